/* include/amo_settings.svh */
`ifndef AMO_SETTINGS_SVH
`define AMO_SETTINGS_SVH

`define AMO_XLEN         32
`define AMO_TAG_WIDTH    4
`define AMO_REG_WIDTH    5
`define AMO_MEM_WORDS    64
`define AMO_VADDR_LIMIT  256  // First faulting address.
`define AMO_MEM_LATENCY  3

`define AMO_EXC_WIDTH    4
`define AMO_EXC_NONE     4'd0
`define AMO_EXC_LAM      4'd4
`define AMO_EXC_SAM      4'd6
`define AMO_EXC_LPF      4'd13
`define AMO_EXC_SPF      4'd15

`endif

/* project.f */
+incdir+include
source/amo_pkg.sv
source/amo_ctrl.sv
source/amo_timer.sv
source/amo_datapath.sv
source/amo_translate.sv
source/amo_mem.sv
source/amo_unit_top.sv
sim/amo_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module amo_unit_tb \
    -f project.f -o amo_unit_sim

./obj_dir/amo_unit_sim 2>&1 | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
echo "Simulation finished without failure"

/* sim/amo_testdata.txt */
// op addr data tag kill flush_delay, all fields in hex
// op: 0 LR, 1 SC, 2 SWAP, 3 ADD, 4 XOR, 5 AND, 6 OR, 7 MIN, 8 MAX, 9 MINU, a MAXU
2 00000010 12345678 1 0 0
3 00000010 00000010 2 0 2
0 00000010 00000000 3 0 1
1 00000010 cafef00d 4 0 3
0 00000010 00000000 5 0 0
4 00000010 ffff0000 6 0 2
1 00000010 11111111 7 0 1
7 00000010 80000000 8 0 0
a 00000010 7fffffff 9 0 4
6 00000014 0000f0f0 a 0 1
5 00000014 000000ff b 0 0
8 00000014 fffffff0 c 0 2
9 00000014 00000010 d 0 1
3 00000016 00000001 e 0 0
0 00000013 00000000 f 0 0
0 00000100 00000000 0 0 4
2 000001fc 5a5a5a5a 1 0 1
2 00000010 deadbeef 2 1 0
0 00000010 00000000 3 0 2
1 00000014 22222222 4 0 0
0 00000014 00000000 5 0 3

/* sim/amo_unit_tb.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_unit_tb;
    logic                      clk;
    logic                      rst;
    logic                      issue_valid;
    logic                      issue_ready;
    amo_pkg::amo_op_t          issue_op;
    logic [`AMO_XLEN-1:0]      issue_addr;
    logic [`AMO_XLEN-1:0]      issue_data;
    logic [`AMO_REG_WIDTH-1:0] issue_rd;
    logic                      issue_we;
    logic [`AMO_TAG_WIDTH-1:0] issue_tag;
    logic                      commit_valid;
    logic [`AMO_TAG_WIDTH-1:0] commit_tag;
    logic                      kill;
    logic                      store_flush;
    logic                      flush_end;
    logic                      wb_valid;
    logic                      wb_ready;
    logic [`AMO_TAG_WIDTH-1:0] wb_tag;
    logic [`AMO_REG_WIDTH-1:0] wb_rd;
    logic                      wb_we;
    logic [`AMO_XLEN-1:0]      wb_data;
    logic [`AMO_EXC_WIDTH-1:0] wb_exc;

    logic [`AMO_XLEN-1:0]      ref_mem [`AMO_MEM_WORDS];
    logic                      ref_resv_valid;
    int                        ref_resv_idx;
    logic [`AMO_XLEN-1:0]      exp_data;
    logic [`AMO_EXC_WIDTH-1:0] exp_exc;
    int                        seed;
    int                        errors;
    int                        checks;
    int                        row_errors;

    amo_unit_top u_dut (.*);

    always #10 clk = ~clk;  // 20 ns period.

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            row_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s at %0t ns", msg, $time);
        errors++;
        row_errors++;
    endtask

    //////////////////////////////
    // Reference AMO model
    //////////////////////////////
    task automatic predict_result(input int op, input logic [31:0] addr,
                                  input logic [31:0] data, input int killed);
        int          idx;
        logic [31:0] old;
        logic [31:0] nxt;
        idx      = int'(addr[7:2]);  // Word index.
        exp_data = '0;
        exp_exc  = `AMO_EXC_NONE;
        if (addr[1:0] != 2'b00) begin
            exp_exc = (op == 0) ? `AMO_EXC_LAM : `AMO_EXC_SAM;
        end else if (addr >= `AMO_VADDR_LIMIT) begin
            exp_exc = (op == 0) ? `AMO_EXC_LPF : `AMO_EXC_SPF;
        end
        if (killed == 0 && exp_exc == `AMO_EXC_NONE) begin
            old = ref_mem[idx];
            case (op)
                3:       nxt = old + data;
                4:       nxt = old ^ data;
                5:       nxt = old & data;
                6:       nxt = old | data;
                7:       nxt = ($signed(old) < $signed(data)) ? old : data;
                8:       nxt = ($signed(old) > $signed(data)) ? old : data;
                9:       nxt = (old < data) ? old : data;
                10:      nxt = (old > data) ? old : data;
                default: nxt = data;
            endcase
            if (op == 0) begin
                exp_data       = old;
                ref_resv_valid = 1'b1;
                ref_resv_idx   = idx;
            end else if (op == 1) begin
                exp_data = (ref_resv_valid && ref_resv_idx == idx) ? 32'd0 : 32'd1;
                if (exp_data == 32'd0) begin
                    ref_mem[idx] = nxt;
                end
                ref_resv_valid = 1'b0;
            end else begin
                exp_data     = old;
                ref_mem[idx] = nxt;
                if (ref_resv_idx == idx) begin
                    ref_resv_valid = 1'b0;  // Write hits the reserved word.
                end
            end
        end
    endtask

    initial begin
        int                        fd;
        int                        n;
        int                        i;
        int                        row;
        int                        op;
        int                        tag;
        int                        kill_flag;
        int                        delay;
        int                        hold_left;
        int                        cycles;
        int                        flush_cnt;
        int                        flush_age;
        logic [31:0]               addr;
        logic [31:0]               data;
        logic [`AMO_REG_WIDTH-1:0] rd_v;
        logic                      we_v;
        logic                      flush_sent;
        logic                      flush_rose;
        logic                      wb_seen;
        logic                      wb_done;
        logic                      finished;
        logic                      aborted;
        logic [`AMO_XLEN-1:0]      snap_data;
        logic [`AMO_TAG_WIDTH-1:0] snap_tag;
        string                     line;

        clk          = 1'b0;
        rst          = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = amo_pkg::AMO_LR;
        issue_addr   = '0;
        issue_data   = '0;
        issue_rd     = '0;
        issue_we     = 1'b0;
        issue_tag    = '0;
        commit_valid = 1'b0;
        commit_tag   = '0;
        kill         = 1'b0;
        flush_end    = 1'b0;
        wb_ready     = 1'b0;
        seed         = 32'h004c5700;
        errors       = 0;
        checks       = 0;
        row_errors   = 0;
        row          = 0;
        aborted      = 1'b0;
        hold_left    = 0;
        for (i = 0; i < `AMO_MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        ref_resv_valid = 1'b0;
        ref_resv_idx   = 0;

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);
        check_value("issue_ready after reset", 32'(issue_ready), 32'd1);
        check_value("store_flush after reset", 32'(store_flush), 32'd0);
        check_value("wb_valid after reset", 32'(wb_valid), 32'd0);

        fd = $fopen("sim/amo_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/amo_testdata.txt");
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n < 2 || line.getc(0) == 8'h2f) begin
                continue;  // Blank or comment line.
            end
            n = $sscanf(line, "%h %h %h %h %h %h", op, addr, data, tag, kill_flag, delay);
            if (n != 6) begin
                continue;
            end
            row++;
            row_errors = 0;
            rd_v       = `AMO_REG_WIDTH'(row + 1);
            we_v       = (row % 3 != 2);
            predict_result(op, addr, data, kill_flag);

            // Issue held until accepted.
            @(posedge clk);
            #2;
            wb_ready    = 1'b0;
            issue_valid = 1'b1;
            issue_op    = amo_pkg::amo_op_t'(op);
            issue_addr  = addr;
            issue_data  = data;
            issue_rd    = rd_v;
            issue_we    = we_v;
            issue_tag   = `AMO_TAG_WIDTH'(tag);
            cycles      = 0;
            @(negedge clk);
            while (!issue_ready && cycles < 20) begin
                cycles++;
                @(negedge clk);
            end
            if (!issue_ready) begin
                $display("Timeout: issue_ready stayed low for row %0d", row);
                aborted = 1'b1;
                break;
            end

            @(posedge clk);
            #2;
            issue_valid = 1'b0;
            if (kill_flag != 0) begin
                kill = 1'b1;
            end else begin
                commit_valid = 1'b1;
                commit_tag   = `AMO_TAG_WIDTH'(tag);
            end

            cycles     = 0;
            flush_cnt  = 0;
            flush_age  = 0;
            flush_sent = 1'b0;
            flush_rose = 1'b0;
            wb_seen    = 1'b0;
            wb_done    = 1'b0;
            finished   = 1'b0;
            while (!finished) begin
                @(posedge clk);
                #2;
                commit_valid = 1'b0;
                kill         = 1'b0;
                if (flush_sent) begin
                    flush_age++;
                end
                flush_end    = store_flush && (flush_cnt >= delay);
                flush_sent   = flush_sent || flush_end;
                if (store_flush) begin
                    flush_cnt++;
                end
                wb_ready = 1'b0;
                if (wb_seen && !wb_done) begin
                    if (hold_left == 0) begin
                        wb_ready = 1'b1;
                    end else begin
                        hold_left--;  // Back-pressure.
                    end
                end

                @(negedge clk);
                cycles++;
                if (store_flush) begin
                    flush_rose = 1'b1;
                end
                if (store_flush && (kill_flag != 0 || addr[1:0] != 2'b00)) begin
                    note_failure("store_flush rose for an operation that needs no drain");
                end
                if (!store_flush && flush_rose && !flush_sent) begin
                    note_failure("store_flush dropped before flush_end");
                end
                if (wb_valid && (kill_flag != 0 || wb_done)) begin
                    note_failure("Writeback appeared where none was due");
                end else if (wb_valid && !wb_seen) begin
                    // Drain end is seen one edge later, then the timed access runs.
                    if (exp_exc == `AMO_EXC_NONE &&
                        (!flush_sent || flush_age < `AMO_MEM_LATENCY + 2)) begin
                        note_failure("Writeback appeared before flush_end and the access");
                    end
                    check_value("wb_tag", 32'(wb_tag), 32'(tag));
                    check_value("wb_rd", 32'(wb_rd), 32'(rd_v));
                    check_value("wb_we", 32'(wb_we), 32'(we_v && exp_exc == `AMO_EXC_NONE));
                    check_value("wb_data", wb_data, exp_data);
                    check_value("wb_exc", 32'(wb_exc), 32'(exp_exc));
                    snap_data = wb_data;
                    snap_tag  = wb_tag;
                    wb_seen   = 1'b1;
                    hold_left = $random(seed) & 3;
                end else if (wb_valid && !wb_done) begin
                    check_value("held wb_data", wb_data, snap_data);
                    check_value("held wb_tag", 32'(wb_tag), 32'(snap_tag));
                end
                if (wb_ready && wb_valid) begin
                    wb_done = 1'b1;
                end
                if (kill_flag != 0) begin
                    finished = (cycles >= 6);  // Quiet window after kill.
                end else begin
                    finished = wb_done && !store_flush;
                end
                if (!finished && cycles > 200) begin
                    $display("Timeout: no writeback or drain end for row %0d", row);
                    aborted = 1'b1;
                    break;
                end
            end
            if (aborted) begin
                break;
            end
            $display("row %0d op %0d addr %h tag %0d kill %0d: %s", row, op, addr, tag,
                     kill_flag, (row_errors == 0) ? "ok" : "FAIL");
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("rows %0d, checks %0d, errors %0d", row, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* source/amo_ctrl.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  logic                      commit_valid,
    input  logic [`AMO_TAG_WIDTH-1:0] commit_tag,
    input  logic                      kill,
    input  logic [`AMO_TAG_WIDTH-1:0] held_tag,
    input  logic                      misaligned,
    input  logic                      xlat_valid,
    input  logic                      xlat_fault,
    input  logic                      flush_end,
    input  logic                      timer_done,
    input  logic                      wb_ready,
    output logic                      issue_ready,
    output logic                      capture,
    output logic                      xlat_req,
    output logic                      store_flush,
    output logic                      timer_start,
    output logic                      mem_exec,
    output logic                      fault_seen,
    output logic                      wb_valid
);
    amo_pkg::amo_state_t state;
    logic                xlat_done;
    logic                flush_done;
    logic                commit_hit;

    assign issue_ready = (state == amo_pkg::IDLE) || (state == amo_pkg::WB && wb_ready);
    assign capture     = issue_valid && issue_ready;
    assign commit_hit  = commit_valid && (commit_tag == held_tag);
    assign mem_exec    = (state == amo_pkg::CACHE) && timer_done;
    assign wb_valid    = (state == amo_pkg::WB);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= amo_pkg::IDLE;
            xlat_req    <= 1'b0;
            store_flush <= 1'b0;
            timer_start <= 1'b0;
            xlat_done   <= 1'b0;
            flush_done  <= 1'b0;
            fault_seen  <= 1'b0;
        end else begin
            xlat_req    <= 1'b0;  // Single cycle pulses.
            timer_start <= 1'b0;
            // Drain completes on its own, even after a fault left TRANSLATE.
            if (store_flush && flush_end) begin
                store_flush <= 1'b0;
                flush_done  <= 1'b1;
            end
            if (capture) begin
                fault_seen <= 1'b0;
            end
            case (state)
                amo_pkg::IDLE: begin
                    if (capture) begin
                        state <= amo_pkg::COMMIT_WAIT;
                    end
                end
                amo_pkg::COMMIT_WAIT: begin
                    if (kill) begin
                        state <= amo_pkg::IDLE;  // Dropped, no writeback.
                    end else if (commit_hit) begin
                        if (misaligned) begin
                            state <= amo_pkg::WB;
                        end else begin
                            state       <= amo_pkg::TRANSLATE;
                            xlat_req    <= 1'b1;
                            store_flush <= 1'b1;
                            xlat_done   <= 1'b0;
                            flush_done  <= 1'b0;
                        end
                    end
                end
                amo_pkg::TRANSLATE: begin
                    if (xlat_valid && xlat_fault) begin
                        state      <= amo_pkg::WB;
                        fault_seen <= 1'b1;
                    end else if (xlat_valid) begin
                        xlat_done <= 1'b1;
                    end
                    if (xlat_done && flush_done) begin
                        state       <= amo_pkg::CACHE;
                        timer_start <= 1'b1;
                    end
                end
                amo_pkg::CACHE: begin
                    if (timer_done) begin
                        state <= amo_pkg::WB;
                    end
                end
                amo_pkg::WB: begin
                    if (wb_ready) begin
                        state <= capture ? amo_pkg::COMMIT_WAIT : amo_pkg::IDLE;
                    end
                end
                default: begin
                    state <= amo_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* source/amo_datapath.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_datapath (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      capture,
    input  amo_pkg::amo_op_t          issue_op,
    input  logic [`AMO_XLEN-1:0]      issue_addr,
    input  logic [`AMO_XLEN-1:0]      issue_data,
    input  logic [`AMO_REG_WIDTH-1:0] issue_rd,
    input  logic                      issue_we,
    input  logic [`AMO_TAG_WIDTH-1:0] issue_tag,
    input  logic                      fault_seen,
    input  logic                      mem_exec,
    input  logic [`AMO_XLEN-1:0]      mem_rdata,
    output logic [`AMO_TAG_WIDTH-1:0] held_tag,
    output amo_pkg::amo_op_t          held_op,
    output logic [`AMO_XLEN-1:0]      held_addr,
    output logic [`AMO_XLEN-1:0]      held_data,
    output logic                      misaligned,
    output logic [`AMO_TAG_WIDTH-1:0] wb_tag,
    output logic [`AMO_REG_WIDTH-1:0] wb_rd,
    output logic                      wb_we,
    output logic [`AMO_XLEN-1:0]      wb_data,
    output logic [`AMO_EXC_WIDTH-1:0] wb_exc
);
    logic [`AMO_REG_WIDTH-1:0] held_rd;
    logic                      held_we;
    logic [`AMO_XLEN-1:0]      result;
    logic                      is_lr;
    logic                      exc_hit;

    assign misaligned = (held_addr[1:0] != 2'b00);
    assign is_lr      = (held_op == amo_pkg::AMO_LR);

    always_comb begin
        if (misaligned) begin
            wb_exc = is_lr ? `AMO_EXC_LAM : `AMO_EXC_SAM;  // Checked first.
        end else if (fault_seen) begin
            wb_exc = is_lr ? `AMO_EXC_LPF : `AMO_EXC_SPF;
        end else begin
            wb_exc = `AMO_EXC_NONE;
        end
    end

    assign exc_hit = (wb_exc != `AMO_EXC_NONE);
    assign wb_tag  = held_tag;
    assign wb_rd   = held_rd;
    assign wb_we   = held_we && !exc_hit;
    assign wb_data = exc_hit ? '0 : result;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held_addr <= '0;
            held_we   <= 1'b0;
            result    <= '0;
        end else begin
            if (capture) begin
                held_addr <= issue_addr;
                held_we   <= issue_we;
            end
            if (mem_exec) begin
                result <= mem_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_tag  <= issue_tag;
            held_op   <= issue_op;
            held_data <= issue_data;
            held_rd   <= issue_rd;
        end
    end

endmodule

/* source/amo_mem.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_mem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              mem_exec,
    input  logic [$clog2(`AMO_MEM_WORDS)-1:0] paddr,
    input  amo_pkg::amo_op_t                  held_op,
    input  logic [`AMO_XLEN-1:0]              held_data,
    output logic [`AMO_XLEN-1:0]              mem_rdata
);
    localparam int IDX_WIDTH = $clog2(`AMO_MEM_WORDS);

    logic [`AMO_XLEN-1:0]  mem [`AMO_MEM_WORDS];
    logic                  resv_valid;
    logic [IDX_WIDTH-1:0]  resv_idx;
    logic [`AMO_XLEN-1:0]  old_word;
    logic [`AMO_XLEN-1:0]  new_word;
    logic                  sc_ok;
    logic                  do_write;

    //////////////////////////////
    // Read-modify-write combine
    //////////////////////////////
    always_comb begin
        old_word = mem[paddr];
        sc_ok    = resv_valid && (resv_idx == paddr);
        case (held_op)
            amo_pkg::AMO_ADD:  new_word = old_word + held_data;
            amo_pkg::AMO_XOR:  new_word = old_word ^ held_data;
            amo_pkg::AMO_AND:  new_word = old_word & held_data;
            amo_pkg::AMO_OR:   new_word = old_word | held_data;
            amo_pkg::AMO_MIN:  new_word = ($signed(old_word) < $signed(held_data)) ?
                                          old_word : held_data;
            amo_pkg::AMO_MAX:  new_word = ($signed(old_word) > $signed(held_data)) ?
                                          old_word : held_data;
            amo_pkg::AMO_MINU: new_word = (old_word < held_data) ? old_word : held_data;
            amo_pkg::AMO_MAXU: new_word = (old_word > held_data) ? old_word : held_data;
            default:           new_word = held_data;  // SWAP and SC.
        endcase
    end

    assign do_write  = mem_exec && (held_op != amo_pkg::AMO_LR) &&
                       ((held_op != amo_pkg::AMO_SC) || sc_ok);
    assign mem_rdata = (held_op == amo_pkg::AMO_SC) ?
                       {{(`AMO_XLEN-1){1'b0}}, !sc_ok} : old_word;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `AMO_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            resv_valid <= 1'b0;
            resv_idx   <= '0;
        end else if (mem_exec) begin
            if (do_write) begin
                mem[paddr] <= new_word;
            end
            if (held_op == amo_pkg::AMO_LR) begin
                resv_valid <= 1'b1;
                resv_idx   <= paddr;
            end else if (held_op == amo_pkg::AMO_SC || resv_idx == paddr) begin
                resv_valid <= 1'b0;  // Consumed or overwritten.
            end
        end
    end

endmodule

/* source/amo_pkg.sv */
package amo_pkg;

    // Operation encoding as carried on issue_op.
    typedef enum logic [3:0] {
        AMO_LR   = 4'd0,
        AMO_SC   = 4'd1,
        AMO_SWAP = 4'd2,
        AMO_ADD  = 4'd3,
        AMO_XOR  = 4'd4,
        AMO_AND  = 4'd5,
        AMO_OR   = 4'd6,
        AMO_MIN  = 4'd7,
        AMO_MAX  = 4'd8,
        AMO_MINU = 4'd9,
        AMO_MAXU = 4'd10
    } amo_op_t;

    typedef enum logic [2:0] {
        IDLE,
        COMMIT_WAIT,
        TRANSLATE,
        CACHE,
        WB
    } amo_state_t;

endpackage

/* source/amo_timer.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_timer (
    input  logic clk,
    input  logic rst,
    input  logic timer_start,
    output logic timer_done
);
    localparam int CNT_WIDTH = $clog2(`AMO_MEM_LATENCY + 1);

    logic [CNT_WIDTH-1:0] count;

    // Last counted cycle of the access.
    assign timer_done = (count == CNT_WIDTH'(1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (timer_start) begin
            count <= CNT_WIDTH'(`AMO_MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

endmodule

/* source/amo_translate.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_translate (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 xlat_req,
    input  logic [`AMO_XLEN-1:0]                 held_addr,
    output logic                                 xlat_valid,
    output logic                                 xlat_fault,
    output logic [$clog2(`AMO_MEM_WORDS)-1:0]    paddr
);
    localparam int IDX_WIDTH = $clog2(`AMO_MEM_WORDS);

    logic page_fault;

    assign page_fault = (held_addr >= `AMO_XLEN'(`AMO_VADDR_LIMIT));

    //////////////////////////////
    // Fixed one-cycle lookup
    //////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            xlat_valid <= 1'b0;
            xlat_fault <= 1'b0;
        end else begin
            xlat_valid <= xlat_req;
            if (xlat_req) begin
                xlat_fault <= page_fault;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xlat_req) begin
            paddr <= held_addr[IDX_WIDTH+1:2];  // Word index.
        end
    end

endmodule

/* source/amo_unit_top.sv */
`timescale 1ns/1ns
`include "amo_settings.svh"

module amo_unit_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  amo_pkg::amo_op_t          issue_op,
    input  logic [`AMO_XLEN-1:0]      issue_addr,
    input  logic [`AMO_XLEN-1:0]      issue_data,
    input  logic [`AMO_REG_WIDTH-1:0] issue_rd,
    input  logic                      issue_we,
    input  logic [`AMO_TAG_WIDTH-1:0] issue_tag,
    input  logic                      commit_valid,
    input  logic [`AMO_TAG_WIDTH-1:0] commit_tag,
    input  logic                      kill,
    output logic                      store_flush,
    input  logic                      flush_end,
    output logic                      wb_valid,
    input  logic                      wb_ready,
    output logic [`AMO_TAG_WIDTH-1:0] wb_tag,
    output logic [`AMO_REG_WIDTH-1:0] wb_rd,
    output logic                      wb_we,
    output logic [`AMO_XLEN-1:0]      wb_data,
    output logic [`AMO_EXC_WIDTH-1:0] wb_exc
);
    logic                              capture, misaligned, fault_seen, mem_exec;
    logic                              xlat_req, xlat_valid, xlat_fault;
    logic                              timer_start, timer_done;
    logic [`AMO_TAG_WIDTH-1:0]         held_tag;
    amo_pkg::amo_op_t                  held_op;
    logic [`AMO_XLEN-1:0]              held_addr, held_data, mem_rdata;
    logic [$clog2(`AMO_MEM_WORDS)-1:0] paddr;

    amo_ctrl u_ctrl (
        .clk, .rst, .issue_valid, .commit_valid, .commit_tag, .kill, .held_tag,
        .misaligned, .xlat_valid, .xlat_fault, .flush_end, .timer_done, .wb_ready,
        .issue_ready, .capture, .xlat_req, .store_flush, .timer_start, .mem_exec,
        .fault_seen, .wb_valid
    );

    amo_timer u_timer (.clk, .rst, .timer_start, .timer_done);

    amo_datapath u_datapath (
        .clk, .rst, .capture, .issue_op, .issue_addr, .issue_data, .issue_rd,
        .issue_we, .issue_tag, .fault_seen, .mem_exec, .mem_rdata, .held_tag,
        .held_op, .held_addr, .held_data, .misaligned, .wb_tag, .wb_rd, .wb_we,
        .wb_data, .wb_exc
    );

    amo_translate u_translate (
        .clk, .rst, .xlat_req, .held_addr, .xlat_valid, .xlat_fault, .paddr
    );

    amo_mem u_mem (.clk, .rst, .mem_exec, .paddr, .held_op, .held_data, .mem_rdata);

endmodule
